//--- verif/ex_golden.txt
# name op men mop br csr csrdata opa opb opc awe awa lwe lwa lddata exp expbr
# all values hex, op is the ALU operator code
add_basic 0 0 0 0 0 00000000 00000005 00000007 00000000 1 01 0 00 00000000 0000000c 0
sub_wrap 1 0 0 0 0 00000000 00000000 00000001 00000000 1 02 0 00 00000000 ffffffff 0
and_mask 2 0 0 0 0 00000000 f0f0f0f0 ff00ff00 00000000 1 03 0 00 00000000 f000f000 0
or_load 3 0 0 0 0 00000000 12340000 00005678 00000000 1 04 1 05 cafe0005 12345678 0
xor_inv 4 0 0 0 0 00000000 aaaaaaaa ffffffff 00000000 1 06 0 00 00000000 55555555 0
sll_top 5 0 0 0 0 00000000 00000001 0000001f 00000000 1 07 0 00 00000000 80000000 0
srl_four 6 0 0 0 0 00000000 80000000 00000004 00000000 1 08 0 00 00000000 08000000 0
sra_four 7 0 0 0 0 00000000 80000000 00000004 00000000 1 09 0 00 00000000 f8000000 0
slt_neg 8 0 0 0 0 00000000 ffffffff 00000001 00000000 1 0a 0 00 00000000 00000001 1
sltu_big 9 0 0 0 0 00000000 ffffffff 00000001 00000000 1 0b 0 00 00000000 00000000 0
csr_read 0 0 0 0 1 0badf00d 00000001 00000001 00000000 1 0c 0 00 00000000 0badf00d 0
mul_low 0 1 0 0 0 00000000 00010003 00020005 00000000 1 0d 0 00 00000000 000b000f 0
mulh_neg 0 1 1 0 0 00000000 ffffffff 00000002 00000000 1 0e 0 00 00000000 ffffffff 0
mulh_big 0 1 1 0 0 00000000 40000000 40000000 00000000 1 0f 0 00 00000000 10000000 0
divu_7 e 0 0 0 0 00000000 00000064 00000007 00000000 1 10 0 00 00000000 0000000e 0
remu_7 f 0 0 0 0 00000000 00000064 00000007 00000000 1 11 0 00 00000000 00000002 0
divu_zero e 0 0 0 0 00000000 12345678 00000000 00000000 1 12 0 00 00000000 ffffffff 0
remu_zero f 0 0 0 0 00000000 12345678 00000000 00000000 1 13 0 00 00000000 12345678 0
beq_taken a 0 0 1 0 00000000 00000005 00000005 00001000 0 00 0 00 00000000 00000001 1
bne_not b 0 0 1 0 00000000 00000005 00000005 00002000 0 00 0 00 00000000 00000000 0
blt_taken c 0 0 1 0 00000000 ffffff00 00000010 00003000 0 00 0 00 00000000 00000001 1
bge_not d 0 0 1 0 00000000 ffffff00 00000010 00004000 0 00 0 00 00000000 00000000 0
add_ld15 0 0 0 0 0 00000000 00000001 00000002 00000000 1 14 1 15 11110015 00000003 0
add_to15 0 0 0 0 0 00000000 00000010 00000020 00000000 1 15 0 00 00000000 00000030 0
write_x0 0 0 0 0 0 00000000 00000001 00000001 00000000 1 00 1 00 deadbeef 00000002 0
xor_x1 4 0 0 0 0 00000000 0f0f0f0f 00ff00ff 00000000 1 01 0 00 00000000 0ff00ff0 0

//--- sources.f
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_stage.sv
rtl/wb_regfile.sv
rtl/ex_subsystem.sv
verif/tb_clk_gen.sv
verif/tb_ex_subsystem.sv

//--- Bender.yml
package:
  name: ex_subsystem

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ex_pkg.sv
      - rtl/ex_alu.sv
      - rtl/ex_mult.sv
      - rtl/ex_stage.sv
      - rtl/wb_regfile.sv
      - rtl/ex_subsystem.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_ex_subsystem.sv

//--- verif/tb_ex_subsystem.sv
/* Testbench for the execute subsystem driven by the golden vector file.
   Random back-pressure on the ready inputs and a register file model for readback. */

`timescale 1ns/1ps

`include "ex_config.svh"

module tb_ex_subsystem;

  localparam int timeout_cycles = 100;

  logic                         clk;
  logic                         rst_n;
  ex_pkg::issue_t               issue_i;
  logic                         lsu_ready_i;
  logic [`EX_XLEN-1:0]          lsu_rdata_i;
  logic                         wb_ready_i;
  logic [$clog2(`EX_NREGS)-1:0] rf_raddr_i;
  ex_pkg::fwd_t                 fwd_o;
  logic [`EX_XLEN-1:0]          jump_target_o;
  logic                         branch_decision_o;
  logic                         ex_ready_o;
  logic                         ex_valid_o;
  logic [`EX_XLEN-1:0]          rf_rdata_o;

  // Register file model and pending load destination
  logic [`EX_XLEN-1:0]          exp_regs [`EX_NREGS];
  logic [`EX_XLEN-1:0]          cur_exp;
  logic                         pend_we;
  logic [$clog2(`EX_NREGS)-1:0] pend_addr;
  int                           seed;

  tb_clk_gen i_tb_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_subsystem i_ex_subsystem (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_i           (issue_i),
    .lsu_ready_i       (lsu_ready_i),
    .lsu_rdata_i       (lsu_rdata_i),
    .wb_ready_i        (wb_ready_i),
    .rf_raddr_i        (rf_raddr_i),
    .fwd_o             (fwd_o),
    .jump_target_o     (jump_target_o),
    .branch_decision_o (branch_decision_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o),
    .rf_rdata_o        (rf_rdata_o)
  );

  task automatic check_equal(input logic [8*16-1:0] name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act)
    else
    begin
      $display("Mismatch in %0s (%0s): expected %08h, actual %08h", name, what, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "wrong value");
    end
  endtask

  task automatic report_timeout(input string msg);
    $display("Timed out: %0s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Register file model updated on every edge after reset
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    logic alu_w;
    logic ld_w;
    if (rst_n)
    begin
      alu_w = issue_i.alu_we && ex_valid_o && (issue_i.alu_waddr != 0);
      ld_w  = pend_we && (pend_addr != 0);
      // Load port wins a same-address write
      if (alu_w && !(ld_w && (pend_addr == issue_i.alu_waddr)))
        exp_regs[issue_i.alu_waddr] = cur_exp;
      if (ld_w)
        exp_regs[pend_addr] = lsu_rdata_i;
      // EX/WB capture or bubble clearing the load write
      if (ex_valid_o)
      begin
        pend_we   = issue_i.ld_we;
        pend_addr = issue_i.ld_waddr;
      end
      else if (wb_ready_i)
        pend_we = 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // One operation from issue to acceptance
  //////////////////////////////////////////////////////////////////////

  task automatic run_vector(input logic [8*16-1:0] name, input ex_pkg::issue_t op,
                            input logic [31:0] ld_data, input logic [31:0] exp_res,
                            input logic exp_br);
    int   cycles;
    logic done;
    logic acc_valid;
    cycles    = 0;
    done      = 1'b0;
    acc_valid = 1'b0;
    issue_i    <= op;
    cur_exp    <= exp_res;
    rf_raddr_i <= op.alu_waddr;
    lsu_ready_i <= (($random(seed) & 3) != 0);
    // Branches must go through with writeback stalled
    wb_ready_i  <= op.branch ? 1'b0 : (($random(seed) & 3) != 0);
    while (!done)
    begin
      @(negedge clk);
      check_equal(name, "register readback", exp_regs[rf_raddr_i], rf_rdata_o);
      // Stall keeps valid low and blocks all but branches
      if (!lsu_ready_i || !wb_ready_i)
      begin
        check_equal(name, "valid under stall", 32'd0, {31'd0, ex_valid_o});
        if (!op.branch)
          check_equal(name, "ready under stall", 32'd0, {31'd0, ex_ready_o});
      end
      if (ex_ready_o)
      begin
        acc_valid = ex_valid_o;
        done      = 1'b1;
        if (op.branch)
        begin
          check_equal(name, "branch decision", {31'd0, exp_br}, {31'd0, branch_decision_o});
          check_equal(name, "jump target", op.op_c, jump_target_o);
        end
        else
        begin
          check_equal(name, "result", exp_res, fwd_o.wdata);
          check_equal(name, "write enable", {31'd0, op.alu_we}, {31'd0, fwd_o.we});
          check_equal(name, "write address", {27'd0, op.alu_waddr}, {27'd0, fwd_o.waddr});
        end
      end
      else
      begin
        assert (!op.branch)
        else
        begin
          $display("Branch %0s was not accepted in its first cycle", name);
          $display("RESULT: FAIL");
          $fatal(1, "branch stalled");
        end
        cycles++;
        if (cycles >= timeout_cycles)
          report_timeout($sformatf("no acceptance of %0s", name));
      end
      @(posedge clk);
      if (!done)
      begin
        lsu_ready_i <= (($random(seed) & 3) != 0);
        wb_ready_i  <= (($random(seed) & 3) != 0);
      end
    end
    // Load data belongs to the cycle after capture
    if (acc_valid)
      lsu_rdata_i <= ld_data;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int                fd;
    int                cnt;
    int                waited;
    string             line;
    logic [8*16-1:0]   name;
    logic [31:0]       f [16];
    ex_pkg::issue_t    op;

    seed        = 32'hb9f65c0c;
    issue_i     = '0;
    lsu_ready_i = 1'b1;
    lsu_rdata_i = '0;
    wb_ready_i  = 1'b1;
    rf_raddr_i  = '0;
    cur_exp     = '0;
    pend_we     = 1'b0;
    pend_addr   = '0;
    for (int i = 0; i < `EX_NREGS; i++)
      exp_regs[i] = '0;

    waited = 0;
    while (!rst_n)
    begin
      @(posedge clk);
      waited++;
      if (waited > 50)
        report_timeout("reset never released");
    end
    @(posedge clk);

    fd = $fopen("verif/ex_golden.txt", "r");
    assert (fd != 0)
    else
    begin
      $display("Could not open the golden vector file");
      $display("RESULT: FAIL");
      $fatal(1, "no vectors");
    end

    while (!$feof(fd))
    begin
      line = "";
      cnt  = $fgets(line, fd);
      cnt  = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                     f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                     f[10], f[11], f[12], f[13], f[14], f[15]);
      // Comment and blank lines do not parse fully
      if (cnt == 17)
      begin
        op            = '0;
        op.alu_op     = ex_pkg::alu_op_e'(f[0][3:0]);
        op.mult_en    = f[1][0];
        op.mult_op    = ex_pkg::mult_op_e'(f[2][0]);
        op.branch     = f[3][0];
        op.csr_access = f[4][0];
        op.csr_rdata  = f[5];
        op.op_a       = f[6];
        op.op_b       = f[7];
        op.op_c       = f[8];
        op.alu_we     = f[9][0];
        op.alu_waddr  = f[10][4:0];
        op.ld_we      = f[11][0];
        op.ld_waddr   = f[12][4:0];
        run_vector(name, op, f[13], f[14], f[15][0]);
      end
    end
    $fclose(fd);

    // Drain with idle operations so the last load lands
    issue_i     <= '0;
    cur_exp     <= '0;
    lsu_ready_i <= 1'b1;
    wb_ready_i  <= 1'b1;
    repeat (3) @(posedge clk);

    for (int r = 0; r < `EX_NREGS; r++)
    begin
      rf_raddr_i <= r[4:0];
      @(negedge clk);
      check_equal("final_regs", $sformatf("x%0d", r), exp_regs[r], rf_rdata_o);
      @(posedge clk);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- verif/tb_clk_gen.sv
/* Testbench clock and reset source, 8 ns period.
   Reset stays low for the first 10 rising edges. */

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #4 clk_o = ~clk_o;
    end
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- rtl/ex_subsystem.sv
/* Execute subsystem top: execute stage feeding the writeback register file.
   Load-store readiness and read data come in from outside. */

`timescale 1ns/1ps

`include "ex_config.svh"

module ex_subsystem (
  input  logic                          clk,
  input  logic                          rst_n,
  input  ex_pkg::issue_t                issue_i,
  input  logic                          lsu_ready_i,
  input  logic [`EX_XLEN-1:0]           lsu_rdata_i,
  input  logic                          wb_ready_i,
  input  logic [$clog2(`EX_NREGS)-1:0]  rf_raddr_i,
  output ex_pkg::fwd_t                  fwd_o,
  output logic [`EX_XLEN-1:0]           jump_target_o,
  output logic                          branch_decision_o,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o,
  output logic [`EX_XLEN-1:0]           rf_rdata_o
);

  // Load destination from EX/WB
  ex_pkg::wb_t wb;

  //////////////////////////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////////////////////////

  ex_stage i_ex_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_i           (issue_i),
    .lsu_ready_i       (lsu_ready_i),
    .wb_ready_i        (wb_ready_i),
    .fwd_o             (fwd_o),
    .wb_o              (wb),
    .jump_target_o     (jump_target_o),
    .branch_decision_o (branch_decision_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Writeback
  //////////////////////////////////////////////////////////////////////

  wb_regfile i_wb_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .fwd_i      (fwd_o),
    .wb_i       (wb),
    .ld_rdata_i (lsu_rdata_i),
    .raddr_i    (rf_raddr_i),
    .rdata_o    (rf_rdata_o)
  );

endmodule

//--- rtl/wb_regfile.sv
/* Writeback register file with ALU and load write ports and one read port.
   Load port wins on a same-address write; register 0 reads zero. */

`timescale 1ns/1ps

`include "ex_config.svh"

module wb_regfile (
  input  logic                          clk,
  input  logic                          rst_n,
  input  ex_pkg::fwd_t                  fwd_i,
  input  ex_pkg::wb_t                   wb_i,
  input  logic [`EX_XLEN-1:0]           ld_rdata_i,
  input  logic [$clog2(`EX_NREGS)-1:0]  raddr_i,
  output logic [`EX_XLEN-1:0]           rdata_o
);

  localparam int unsigned aw = $clog2(`EX_NREGS);

  logic [`EX_XLEN-1:0] regs [`EX_NREGS];

  // Hardwired zero, writes dropped
  assign regs[0] = '0;

  for (genvar i = 1; i < `EX_NREGS; i++)
  begin : g_reg
    localparam logic [aw-1:0] reg_addr = aw'(i);

    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        regs[i] <= '0;
      end
      else if (wb_i.we && (wb_i.waddr == reg_addr))
      begin
        // Load data first
        regs[i] <= ld_rdata_i;
      end
      else if (fwd_i.we && (fwd_i.waddr == reg_addr))
      begin
        regs[i] <= fwd_i.wdata;
      end
    end
  end

  // Combinational read for inspection
  assign rdata_o = regs[raddr_i];

endmodule

//--- rtl/ex_stage.sv
/* Execute stage hosting ALU and multiplier, result mux and EX/WB register.
   Results forward combinationally; ready and valid come from the unit readies. */

`timescale 1ns/1ps

`include "ex_config.svh"

module ex_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  ex_pkg::issue_t      issue_i,
  input  logic                lsu_ready_i,
  input  logic                wb_ready_i,
  output ex_pkg::fwd_t        fwd_o,
  output ex_pkg::wb_t         wb_o,
  output logic [`EX_XLEN-1:0] jump_target_o,
  output logic                branch_decision_o,
  output logic                ex_ready_o,
  output logic                ex_valid_o
);

  logic [`EX_XLEN-1:0] alu_result;
  logic [`EX_XLEN-1:0] mult_result;
  logic [`EX_XLEN-1:0] alu_csr_result;
  logic                alu_cmp;
  logic                alu_ready;
  logic                mult_ready;

  //////////////////////////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////////////////////////

  ex_alu i_ex_alu (
    .clk                 (clk),
    .rst_n               (rst_n),
    .operator_i          (issue_i.alu_op),
    .operand_a_i         (issue_i.op_a),
    .operand_b_i         (issue_i.op_b),
    .ex_ready_i          (ex_ready_o),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp),
    .ready_o             (alu_ready)
  );

  ex_mult i_ex_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable_i   (issue_i.mult_en),
    .operator_i (issue_i.mult_op),
    .op_a_i     (issue_i.op_a),
    .op_b_i     (issue_i.op_b),
    .ex_ready_i (ex_ready_o),
    .result_o   (mult_result),
    .ready_o    (mult_ready)
  );

  // Result mux, multiplier over CSR over ALU
  assign alu_csr_result = issue_i.csr_access ? issue_i.csr_rdata : alu_result;

  // Stalled ops never write
  assign fwd_o.we    = issue_i.alu_we & ex_valid_o;
  assign fwd_o.waddr = issue_i.alu_waddr;
  assign fwd_o.wdata = issue_i.mult_en ? mult_result : alu_csr_result;

  // Branch target and decision straight out
  assign jump_target_o     = issue_i.op_c;
  assign branch_decision_o = alu_cmp;

  //////////////////////////////////////////////////////////////////////
  // EX/WB register and stall control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_o <= '0;
    end
    else if (ex_valid_o)
    begin
      wb_o.we    <= issue_i.ld_we;
      wb_o.waddr <= issue_i.ld_waddr;
    end
    else if (wb_ready_i)
    begin
      // Bubble, flush the load write
      wb_o.we <= 1'b0;
    end
  end

  // Branches finish here, so ready does not wait on WB
  assign ex_valid_o = alu_ready & mult_ready & lsu_ready_i & wb_ready_i;
  assign ex_ready_o = ex_valid_o | issue_i.branch;

endmodule

//--- rtl/ex_mult.sv
/* Multiplier of the execute stage.
   MUL answers in the issue cycle; MULH stalls through ready until the high word is held. */

`timescale 1ns/1ps

`include "ex_config.svh"

module ex_mult (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                enable_i,
  input  ex_pkg::mult_op_e    operator_i,
  input  logic [`EX_XLEN-1:0] op_a_i,
  input  logic [`EX_XLEN-1:0] op_b_i,
  input  logic                ex_ready_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                ready_o
);

  typedef enum logic [1:0] {IDLE, BUSY, DONE} mulh_state_e;

  // IDLE cycle, BUSY cycles, then DONE make up the full latency
  localparam int unsigned cnt_w = $clog2(`EX_MULH_CYCLES);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`EX_MULH_CYCLES - 3);

  mulh_state_e                state_q;
  logic [cnt_w-1:0]           cnt_q;
  logic                       mulh_start;
  logic [`EX_XLEN-1:0]        mul_lo;
  logic [`EX_XLEN-1:0]        a_q;
  logic [`EX_XLEN-1:0]        b_q;
  logic signed [2*`EX_XLEN-1:0] mulh_prod;
  logic [`EX_XLEN-1:0]        hi_q;

  assign mulh_start = enable_i && (operator_i == ex_pkg::MULT_MULH);

  // Low word, same for signed and unsigned operands
  assign mul_lo = op_a_i * op_b_i;

  // Full signed product from the captured operands, multicycle path
  assign mulh_prod = $signed(a_q) * $signed(b_q);

  //////////////////////////////////////////////////////////////////////
  // MULH sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          if (mulh_start)
          begin
            state_q <= BUSY;
            cnt_q   <= '0;
          end
        end
        BUSY:
        begin
          if (cnt_q == cnt_last)
          begin
            state_q <= DONE;
          end
          cnt_q <= cnt_q + 1'b1;
        end
        default:
        begin
          // Hold the high word through back-pressure
          if (ex_ready_i)
          begin
            state_q <= IDLE;
          end
        end
      endcase
    end
  end

  // Operands in at start, high word out on the last BUSY cycle
  always_ff @(posedge clk)
  begin
    if ((state_q == IDLE) && mulh_start)
    begin
      a_q <= op_a_i;
      b_q <= op_b_i;
    end
    if ((state_q == BUSY) && (cnt_q == cnt_last))
    begin
      hi_q <= mulh_prod[2*`EX_XLEN-1:`EX_XLEN];
    end
  end

  assign result_o = (operator_i == ex_pkg::MULT_MULH) ? hi_q : mul_lo;
  assign ready_o  = (state_q == DONE) || ((state_q == IDLE) && !mulh_start);

endmodule

//--- rtl/ex_alu.sv
/* Execute-stage ALU with arithmetic, logic, shift and compare results.
   DIVU and REMU run an iterative divider and hold ready low until done. */

`timescale 1ns/1ps

`include "ex_config.svh"

module ex_alu (
  input  logic                clk,
  input  logic                rst_n,
  input  ex_pkg::alu_op_e     operator_i,
  input  logic [`EX_XLEN-1:0] operand_a_i,
  input  logic [`EX_XLEN-1:0] operand_b_i,
  input  logic                ex_ready_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                comparison_result_o,
  output logic                ready_o
);

  typedef enum logic [1:0] {IDLE, RUN, DONE} div_state_e;

  localparam int unsigned cnt_w = $clog2(`EX_DIV_CYCLES);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`EX_DIV_CYCLES - 1);

  logic [$clog2(`EX_XLEN)-1:0] shamt;
  logic                        lt_s;
  logic                        lt_u;
  logic                        eq;
  logic                        div_op;

  div_state_e                  div_state_q;
  logic [cnt_w-1:0]            div_cnt_q;
  logic [`EX_XLEN-1:0]         div_quot_q;
  logic [`EX_XLEN-1:0]         div_rem_q;
  logic [`EX_XLEN-1:0]         div_den_q;
  logic [`EX_XLEN:0]           div_shift;
  logic [`EX_XLEN+1:0]         div_trial;

  assign shamt  = operand_b_i[$clog2(`EX_XLEN)-1:0];
  assign lt_s   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_u   = operand_a_i < operand_b_i;
  assign eq     = operand_a_i == operand_b_i;
  assign div_op = (operator_i == ex_pkg::ALU_DIVU) || (operator_i == ex_pkg::ALU_REMU);

  //////////////////////////////////////////////////////////////////////
  // Comparisons and single-cycle results
  //////////////////////////////////////////////////////////////////////

  // Branch and set-less-than decisions
  always_comb
  begin
    case (operator_i)
      ex_pkg::ALU_EQ:   comparison_result_o = eq;
      ex_pkg::ALU_NE:   comparison_result_o = !eq;
      ex_pkg::ALU_LT,
      ex_pkg::ALU_SLT:  comparison_result_o = lt_s;
      ex_pkg::ALU_GE:   comparison_result_o = !lt_s;
      ex_pkg::ALU_SLTU: comparison_result_o = lt_u;
      default:          comparison_result_o = 1'b0;
    endcase
  end

  always_comb
  begin
    case (operator_i)
      ex_pkg::ALU_ADD:  result_o = operand_a_i + operand_b_i;
      ex_pkg::ALU_SUB:  result_o = operand_a_i - operand_b_i;
      ex_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
      ex_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
      ex_pkg::ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Quotient and remainder only valid once the divider is in DONE
      ex_pkg::ALU_DIVU: result_o = div_quot_q;
      ex_pkg::ALU_REMU: result_o = div_rem_q;
      // Compare ops return the decision in bit 0
      default:          result_o = {{(`EX_XLEN-1){1'b0}}, comparison_result_o};
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Restoring divider
  //////////////////////////////////////////////////////////////////////

  // Next dividend bit shifted into the partial remainder
  assign div_shift = {div_rem_q, div_quot_q[`EX_XLEN-1]};
  // Negative trial means the divisor does not fit
  assign div_trial = {1'b0, div_shift} - {2'b00, div_den_q};

  // Sequencer, DONE waits for the stage to accept the result
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_state_q <= IDLE;
      div_cnt_q   <= '0;
    end
    else
    begin
      case (div_state_q)
        IDLE:
        begin
          if (div_op)
          begin
            div_state_q <= RUN;
            div_cnt_q   <= '0;
          end
        end
        RUN:
        begin
          if (div_cnt_q == cnt_last)
          begin
            div_state_q <= DONE;
          end
          div_cnt_q <= div_cnt_q + 1'b1;
        end
        default:
        begin
          if (ex_ready_i)
          begin
            div_state_q <= IDLE;
          end
        end
      endcase
    end
  end

  // One quotient bit per RUN cycle
  // Zero divisor never borrows, so quotient ends all ones and remainder equals dividend
  always_ff @(posedge clk)
  begin
    if ((div_state_q == IDLE) && div_op)
    begin
      div_quot_q <= operand_a_i;
      div_rem_q  <= '0;
      div_den_q  <= operand_b_i;
    end
    else if (div_state_q == RUN)
    begin
      if (div_trial[`EX_XLEN+1])
      begin
        div_rem_q <= div_shift[`EX_XLEN-1:0];
      end
      else
      begin
        div_rem_q <= div_trial[`EX_XLEN-1:0];
      end
      div_quot_q <= {div_quot_q[`EX_XLEN-2:0], !div_trial[`EX_XLEN+1]};
    end
  end

  // Stall from divide issue until the result sits in DONE
  assign ready_o = (div_state_q == DONE) || ((div_state_q == IDLE) && !div_op);

endmodule

//--- rtl/ex_pkg.sv
/* Shared operator encodings and bundles of the execute subsystem.
   Members are referenced by scoped names. */

`include "ex_config.svh"

package ex_pkg;

  //////////////////////////////////////////////////////////////////////
  // Operator encodings
  //////////////////////////////////////////////////////////////////////

  // ALU operators, codes match the golden vectors
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_DIVU = 4'd14,
    ALU_REMU = 4'd15
  } alu_op_e;

  // Low product or signed high product
  typedef enum logic {
    MULT_MUL  = 1'b0,
    MULT_MULH = 1'b1
  } mult_op_e;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////

  // One decoded operation from issue
  typedef struct packed {
    alu_op_e                      alu_op;
    logic [`EX_XLEN-1:0]          op_a;
    logic [`EX_XLEN-1:0]          op_b;
    // Jump target for branches
    logic [`EX_XLEN-1:0]          op_c;
    logic                         mult_en;
    mult_op_e                     mult_op;
    logic                         branch;
    logic                         csr_access;
    logic [`EX_XLEN-1:0]          csr_rdata;
    // ALU write path destination
    logic                         alu_we;
    logic [$clog2(`EX_NREGS)-1:0] alu_waddr;
    // Load write path destination
    logic                         ld_we;
    logic [$clog2(`EX_NREGS)-1:0] ld_waddr;
  } issue_t;

  // Forwarded result into the register file
  typedef struct packed {
    logic                         we;
    logic [$clog2(`EX_NREGS)-1:0] waddr;
    logic [`EX_XLEN-1:0]          wdata;
  } fwd_t;

  // Load destination held in EX/WB
  typedef struct packed {
    logic                         we;
    logic [$clog2(`EX_NREGS)-1:0] waddr;
  } wb_t;

endpackage

//--- rtl/ex_config.svh
/* Build-time sizing for the execute subsystem.
   Include wherever widths, register count or unit latencies are needed. */

`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Datapath width in bits
`define EX_XLEN 32

// Architectural registers, register 0 hardwired to zero
`define EX_NREGS 32

// Divider iterations, one quotient bit per cycle
`define EX_DIV_CYCLES 32

// Cycles from MULH issue to accepted result, at least 3
`define EX_MULH_CYCLES 4

`endif
